//--- project.f
+incdir+logic
logic/aes_pkg.sv
logic/aes_round.sv
logic/aes_key_expand.sv
logic/aes_round_ctrl.sv
logic/aes_core_top.sv
testbench/tb_aes_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_aes_core -f project.f -o tb_aes_core

out=$(./obj_dir/tb_aes_core)
echo "$out"

if echo "$out" | grep -q "sim passed"; then
    exit 0
else
    exit 1
fi

//--- testbench/tb_aes_core.sv
`include "aes_cfg.svh"

module tb_aes_core;

    localparam int clk_half = 10;
    localparam int drive_delay = 2;
    localparam int reset_cycles = 8;
    localparam int hold_cycles = 5;
    // reset plus about 8 blocks of 20 cycles each with margin
    localparam int max_cycles = 400;

    // fips-197 appendix b
    localparam aes_pkg::aes_block_t key_b    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_pkg::aes_block_t plain_b  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_pkg::aes_block_t cipher_b = 128'h3925841d02dc09fbdc118597196a0b32;

    // fips-197 appendix c.1
    localparam aes_pkg::aes_block_t key_c    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::aes_block_t plain_c  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::aes_block_t cipher_c = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    localparam aes_pkg::aes_block_t cipher_zero = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic                clk;
    logic                rst_n;
    logic                req;
    aes_pkg::aes_req_t   req_data;
    logic                ack;
    aes_pkg::aes_block_t cipher;
    int unsigned         cycle_count = 0;

    aes_core_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .cipher   (cipher)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #clk_half clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: ack never arrived within %0d cycles", max_cycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string test_name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // outputs are read well after the edge
    task automatic next_cycle;
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic send_block(input aes_pkg::aes_block_t key, input aes_pkg::aes_block_t plain,
                              output aes_pkg::aes_block_t result, output int latency);
        req_data.key   = key;
        req_data.plain = plain;
        req            = 1'b1;
        latency        = 0;
        // first edge accepts the request
        next_cycle();
        while (!ack)
        begin
            next_cycle();
            latency++;
        end
        result = cipher;
    endtask

    task automatic release_block(input string test_name);
        req = 1'b0;
        next_cycle();
        check_value({test_name, " ack low after release"}, 128'd0, {127'd0, ack});
    endtask

    task automatic test_reset_ack;
        repeat (3)
        begin
            check_value("reset ack low", 128'd0, {127'd0, ack});
            next_cycle();
        end
    endtask

    task automatic test_vector(input string test_name, input aes_pkg::aes_block_t key,
                               input aes_pkg::aes_block_t plain,
                               input aes_pkg::aes_block_t expected);
        aes_pkg::aes_block_t result;
        int                  latency;
        send_block(key, plain, result, latency);
        check_value(test_name, expected, result);
        release_block(test_name);
    endtask

    task automatic test_latency;
        aes_pkg::aes_block_t result;
        int                  latency;
        send_block(key_c, plain_c, result, latency);
        check_value("latency", 128'(`AES_NUM_ROUNDS + 1), 128'(latency));
        check_value("latency cipher", cipher_c, result);
        release_block("latency");
    endtask

    task automatic test_back_pressure;
        aes_pkg::aes_block_t held;
        int                  latency;
        send_block(key_b, plain_b, held, latency);
        check_value("back pressure cipher", cipher_b, held);
        repeat (hold_cycles)
        begin
            next_cycle();
            check_value("back pressure ack held", 128'd1, {127'd0, ack});
            check_value("back pressure cipher held", cipher_b, cipher);
        end
        release_block("back pressure");
        test_vector("back pressure next block", key_b, plain_b, cipher_b);
    endtask

    initial
    begin
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        next_cycle();

        test_reset_ack();
        test_vector("vector b", key_b, plain_b, cipher_b);
        test_vector("vector c", key_c, plain_c, cipher_c);
        // straight after c with no reset in between
        test_vector("zero key", '0, '0, cipher_zero);
        test_latency();
        test_back_pressure();

        $display("sim passed");
        $finish;
    end

endmodule

//--- logic/aes_core_top.sv
module aes_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  aes_pkg::aes_req_t   req_data,
    output logic                ack,
    output aes_pkg::aes_block_t cipher
);

    aes_pkg::aes_block_t state_q;
    aes_pkg::aes_block_t round_key_q;
    aes_pkg::aes_block_t next_key;
    aes_pkg::aes_block_t round_out;
    aes_pkg::aes_round_t round_num;
    logic                final_round;

    aes_round_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_data    (req_data),
        .round_out   (round_out),
        .next_key    (next_key),
        .state_q     (state_q),
        .round_key_q (round_key_q),
        .round_num   (round_num),
        .final_round (final_round),
        .ack         (ack)
    );

    aes_round u_round (
        .state_in    (state_q),
        .round_key   (next_key),
        .final_round (final_round),
        .state_out   (round_out)
    );

    aes_key_expand u_key_expand (
        .key_in    (round_key_q),
        .round_num (round_num),
        .key_out   (next_key)
    );

    // state register holds the ciphertext in DONE
    assign cipher = state_q;

endmodule

//--- logic/aes_round_ctrl.sv
`include "aes_cfg.svh"

module aes_round_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  aes_pkg::aes_req_t   req_data,
    input  aes_pkg::aes_block_t round_out,
    input  aes_pkg::aes_block_t next_key,
    output aes_pkg::aes_block_t state_q,
    output aes_pkg::aes_block_t round_key_q,
    output aes_pkg::aes_round_t round_num,
    output logic                final_round,
    output logic                ack
);

    aes_pkg::aes_state_e fsm_q;
    logic                accept;

    assign accept = (fsm_q == aes_pkg::IDLE) && req;

    assign final_round = (fsm_q == aes_pkg::ROUND)
                       && (round_num == aes_pkg::aes_round_t'(`AES_NUM_ROUNDS));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fsm_q     <= aes_pkg::IDLE;
            round_num <= '0;
            ack       <= 1'b0;
        end
        else
        begin
            case (fsm_q)
                aes_pkg::IDLE:
                begin
                    if (req)
                    begin
                        fsm_q     <= aes_pkg::ROUND;
                        round_num <= aes_pkg::aes_round_t'(1);
                    end
                end
                aes_pkg::ROUND:
                begin
                    if (final_round)
                    begin
                        fsm_q <= aes_pkg::DONE;
                    end
                    else
                    begin
                        round_num <= round_num + 1'b1;
                    end
                end
                aes_pkg::DONE:
                begin
                    // ack goes out one cycle after the last round
                    if (!ack)
                    begin
                        ack <= 1'b1;
                    end
                    else if (!req)
                    begin
                        ack   <= 1'b0;
                        fsm_q <= aes_pkg::IDLE;
                    end
                end
                default:
                begin
                    fsm_q <= aes_pkg::IDLE;
                end
            endcase
        end
    end

    // initial addroundkey on accept then one round per cycle
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            state_q     <= req_data.plain ^ req_data.key;
            round_key_q <= req_data.key;
        end
        else if (fsm_q == aes_pkg::ROUND)
        begin
            state_q     <= round_out;
            round_key_q <= next_key;
        end
    end

    // req seen at the edge that set ack
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
        (fsm_q == aes_pkg::ROUND) |-> (round_num >= 1 && round_num <= `AES_NUM_ROUNDS));

    // requester must hold the block until ack
    a_req_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) ##1 (req && !ack) |-> $stable(req_data));

endmodule

//--- logic/aes_key_expand.sv
`include "aes_cfg.svh"

module aes_key_expand (
    input  aes_pkg::aes_block_t key_in,
    input  aes_pkg::aes_round_t round_num,
    output aes_pkg::aes_block_t key_out
);

    localparam int byte_w = `AES_BYTE_BITS;
    localparam int word_w = 4 * byte_w;

    logic [word_w-1:0] w [4];
    logic [word_w-1:0] n [4];
    logic [word_w-1:0] rot_w;
    logic [word_w-1:0] sub_w;
    logic [word_w-1:0] temp_w;

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            w[i] = key_in[`AES_KEY_BITS-1 - i*word_w -: word_w];
        end
    end

    // rotword then subword on w3
    assign rot_w = {w[3][word_w-byte_w-1:0], w[3][word_w-1 -: byte_w]};

    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            sub_w[j*byte_w +: byte_w] = aes_pkg::sbox(rot_w[j*byte_w +: byte_w]);
        end
    end

    assign temp_w = sub_w ^ {aes_pkg::rcon(round_num), {(word_w - byte_w){1'b0}}};

    // each new word chains off the one before
    always_comb
    begin
        n[0] = w[0] ^ temp_w;
        for (int i = 1; i < 4; i++)
        begin
            n[i] = w[i] ^ n[i-1];
        end
        key_out = {n[0], n[1], n[2], n[3]};
    end

endmodule

//--- logic/aes_round.sv
`include "aes_cfg.svh"

module aes_round (
    input  aes_pkg::aes_block_t state_in,
    input  aes_pkg::aes_block_t round_key,
    input  logic                final_round,
    output aes_pkg::aes_block_t state_out
);

    localparam int byte_w = `AES_BYTE_BITS;
    localparam int num_bytes = `AES_BLOCK_BITS / byte_w;

    logic [byte_w-1:0] sub_b [num_bytes];
    logic [byte_w-1:0] shift_b [num_bytes];
    logic [byte_w-1:0] mix_b [num_bytes];

    // byte 0 sits in the top bits
    always_comb
    begin
        for (int i = 0; i < num_bytes; i++)
        begin
            sub_b[i] = aes_pkg::sbox(state_in[`AES_BLOCK_BITS-1 - i*byte_w -: byte_w]);
        end
    end

    // row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shift_b[4*c + r] = sub_b[4*((c + r) % 4) + r];
            end
        end
    end

    // per column: a_r ^ sum ^ 2*(a_r ^ a_r+1)
    always_comb
    begin
        logic [byte_w-1:0] col_sum;
        for (int c = 0; c < 4; c++)
        begin
            col_sum = shift_b[4*c] ^ shift_b[4*c + 1] ^ shift_b[4*c + 2] ^ shift_b[4*c + 3];
            for (int r = 0; r < 4; r++)
            begin
                mix_b[4*c + r] = shift_b[4*c + r] ^ col_sum
                               ^ aes_pkg::xtime(shift_b[4*c + r] ^ shift_b[4*c + (r + 1) % 4]);
            end
        end
    end

    // last round has no mixcolumns
    always_comb
    begin
        for (int i = 0; i < num_bytes; i++)
        begin
            state_out[`AES_BLOCK_BITS-1 - i*byte_w -: byte_w] =
                (final_round ? shift_b[i] : mix_b[i])
                ^ round_key[`AES_BLOCK_BITS-1 - i*byte_w -: byte_w];
        end
    end

endmodule

//--- logic/aes_pkg.sv
`include "aes_cfg.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;
    typedef logic [`AES_ROUND_BITS-1:0] aes_round_t;

    typedef struct packed {
        logic [`AES_KEY_BITS-1:0] key;
        aes_block_t               plain;
    } aes_req_t;

    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        DONE
    } aes_state_e;

    // forward s-box, entry 0x00 in the top byte
    localparam logic [256*`AES_BYTE_BITS-1:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [`AES_BYTE_BITS-1:0] sbox(input logic [`AES_BYTE_BITS-1:0] b);
        // ~b counts entries from the bottom of the table
        return sbox_table[{~b, 3'b000} +: `AES_BYTE_BITS];
    endfunction

    function automatic logic [`AES_BYTE_BITS-1:0] xtime(input logic [`AES_BYTE_BITS-1:0] b);
        logic [`AES_BYTE_BITS-1:0] shifted;
        shifted = {b[`AES_BYTE_BITS-2:0], 1'b0};
        // reduce by x^8 + x^4 + x^3 + x + 1
        return b[`AES_BYTE_BITS-1] ? (shifted ^ 8'h1b) : shifted;
    endfunction

    function automatic logic [`AES_BYTE_BITS-1:0] rcon(input aes_round_t round);
        case (round)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage

//--- logic/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// data block and key widths
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 128

// one state byte
`define AES_BYTE_BITS 8

// aes-128 round count
`define AES_NUM_ROUNDS 10

// wide enough for rounds 0 to 10
`define AES_ROUND_BITS 4

`endif
